// File: verilog/sdram_pkg.sv
/* command codes, timing and mode constants, request/command structs,
   the dual-view SDRAM address union and the write FSM phase enum */
package sdram_pkg;

    // command codes as {cs_n, ras_n, cas_n, we_n}
    localparam logic [3:0] CMD_NOP       = 4'b0111;
    localparam logic [3:0] CMD_ACTIVE    = 4'b0011;
    localparam logic [3:0] CMD_WRITE     = 4'b0100;
    localparam logic [3:0] CMD_BSTOP     = 4'b0110;
    localparam logic [3:0] CMD_PRECHARGE = 4'b0010;
    localparam logic [3:0] CMD_REFRESH   = 4'b0001;
    localparam logic [3:0] CMD_MODE      = 4'b0000;

    // waits in sys_clk cycles
    localparam logic [9:0] T_POWERUP = 10'd50;   // shortened for simulation
    localparam logic [9:0] TRP_CLK   = 10'd2;
    localparam logic [9:0] TRFC_CLK  = 10'd7;
    localparam logic [9:0] TMRD_CLK  = 10'd2;
    localparam logic [9:0] TRCD_CLK  = 10'd2;

    // full page, sequential, CL3, burst write
    localparam logic [12:0] MODE_WORD = 13'b000_0_00_011_0_111;

    localparam logic [1:0]  IDLE_BA   = 2'b11;
    localparam logic [12:0] IDLE_ADDR = 13'h1fff;

    typedef struct packed {
        logic [1:0]  bank;
        logic [12:0] row;
        logic [8:0]  col;
    } wr_addr_t;

    // address pins as seen by READ/WRITE and PRECHARGE
    typedef struct packed {
        logic [1:0] zero_hi;
        logic       a10;      // auto-precharge on WRITE, all banks on PRECHARGE
        logic       zero_lo;
        logic [8:0] col;
    } sdram_col_t;

    typedef union packed {
        logic [12:0] row;     // ACTIVE and MODE
        sdram_col_t  col;
    } sdram_addr_u;

    typedef struct packed {
        logic [3:0]  cmd;
        logic [1:0]  ba;
        sdram_addr_u addr;
    } sdram_cmd_t;

    localparam sdram_cmd_t IDLE_CMD = sdram_cmd_t'({CMD_NOP, IDLE_BA, IDLE_ADDR});

    typedef enum logic [2:0] {
        WR_IDLE   = 3'b000,
        WR_ACTIVE = 3'b001,
        WR_TRCD   = 3'b011,
        WR_WRITE  = 3'b010,
        WR_DATA   = 3'b100,
        WR_PRE    = 3'b101,
        WR_TRP    = 3'b111,
        WR_END    = 3'b110
    } wr_phase_e;

endpackage

// File: verilog/sdram_cycle_timer.sv
/* loadable wait-interval down-counter */
`timescale 1ns/1ps

module sdram_cycle_timer (
    input  logic       sys_clk,
    input  logic       sys_rst,
    input  logic       load,
    input  logic [9:0] load_val,
    output logic       done
);

    logic [9:0] cnt;   // cycles left in the interval

    // a load of N gives done in the Nth cycle after the load
    always_ff @(posedge sys_clk or negedge sys_rst) begin
        if (!sys_rst) begin
            cnt <= '0;
        end else if (load) begin
            cnt <= (load_val == '0) ? '0 : load_val - 10'd1;
        end else if (cnt != '0) begin
            cnt <= cnt - 10'd1;   // hold at zero
        end
    end

    // a fresh load masks a stale zero
    assign done = (cnt == '0) && !load;

endmodule

// File: verilog/sdram_init.sv
/* power-up initialisation FSM: wait, precharge all, two refreshes,
   mode register load, then a permanent init_end */
`timescale 1ns/1ps

module sdram_init import sdram_pkg::*; (
    input  logic       sys_clk,
    input  logic       sys_rst,
    input  logic       tmr_done,
    output logic       tmr_load,
    output logic [9:0] tmr_val,
    output sdram_cmd_t init_cmd,
    output logic       init_end
);

    typedef enum logic [3:0] {
        I_IDLE, I_WAIT, I_PRE, I_TRP, I_REF1, I_TRFC1,
        I_REF2, I_TRFC2, I_MODE, I_TMRD, I_DONE
    } init_state_e;

    init_state_e state;
    init_state_e state_nxt;

    always_ff @(posedge sys_clk or negedge sys_rst) begin
        if (!sys_rst) begin
            state <= I_IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    // wait states leave on the timer loaded by the state before them
    always_comb begin
        state_nxt = state;
        case (state)
            I_IDLE:  state_nxt = I_WAIT;
            I_WAIT:  state_nxt = tmr_done ? I_PRE : I_WAIT;
            I_PRE:   state_nxt = I_TRP;
            I_TRP:   state_nxt = tmr_done ? I_REF1 : I_TRP;
            I_REF1:  state_nxt = I_TRFC1;
            I_TRFC1: state_nxt = tmr_done ? I_REF2 : I_TRFC1;
            I_REF2:  state_nxt = I_TRFC2;
            I_TRFC2: state_nxt = tmr_done ? I_MODE : I_TRFC2;
            I_MODE:  state_nxt = I_TMRD;
            I_TMRD:  state_nxt = tmr_done ? I_DONE : I_TMRD;
            default: state_nxt = I_DONE;
        endcase
    end

    always_comb begin
        init_cmd = IDLE_CMD;
        tmr_load = 1'b0;
        tmr_val  = '0;
        case (state)
            I_IDLE: begin
                // the reset NOP and this one count toward the power-up NOPs
                tmr_load = 1'b1;
                tmr_val  = T_POWERUP - 10'd2;
            end
            I_PRE: begin
                init_cmd.cmd          = CMD_PRECHARGE;
                init_cmd.addr.col     = '0;
                init_cmd.addr.col.a10 = 1'b1;   // all banks
                tmr_load              = 1'b1;
                tmr_val               = TRP_CLK;
            end
            I_REF1, I_REF2: begin
                init_cmd.cmd = CMD_REFRESH;
                tmr_load     = 1'b1;
                tmr_val      = TRFC_CLK;
            end
            I_MODE: begin
                init_cmd.cmd      = CMD_MODE;
                init_cmd.ba       = 2'b00;
                init_cmd.addr.row = MODE_WORD;
                tmr_load          = 1'b1;
                tmr_val           = TMRD_CLK;
            end
            default: ;   // NOP while waiting
        endcase
    end

    // rises once the last tMRD NOP is on the bus
    always_ff @(posedge sys_clk or negedge sys_rst) begin
        if (!sys_rst) begin
            init_end <= 1'b0;
        end else if (state == I_DONE) begin
            init_end <= 1'b1;
        end
    end

endmodule

// File: verilog/sdram_write_fsm.sv
/* full-page burst write FSM: ACTIVE, tRCD, WRITE, data beats, BURST STOP,
   PRECHARGE all, tRP and the end pulse */
`timescale 1ns/1ps

module sdram_write_fsm import sdram_pkg::*; (
    input  logic       sys_clk,
    input  logic       sys_rst,
    input  logic       init_end,
    input  logic       wr_en,
    input  wr_addr_t   wr_req,
    input  logic [9:0] wr_burst_len,
    input  logic       tmr_done,
    output logic       tmr_load,
    output logic [9:0] tmr_val,
    output wr_phase_e  phase,
    output sdram_cmd_t wr_cmd,
    output logic       wr_end
);

    wr_phase_e state;
    wr_phase_e state_nxt;

    assign phase = state;

    always_ff @(posedge sys_clk or negedge sys_rst) begin
        if (!sys_rst) begin
            state <= WR_IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    always_comb begin
        state_nxt = state;
        case (state)
            WR_IDLE: begin
                // wr_end still high means wr_en is the old burst's level
                if (init_end && wr_en && !wr_end) begin
                    state_nxt = WR_ACTIVE;
                end
            end
            WR_ACTIVE: state_nxt = WR_TRCD;
            WR_TRCD:   state_nxt = tmr_done ? WR_WRITE : WR_TRCD;
            WR_WRITE:  state_nxt = WR_DATA;
            WR_DATA:   state_nxt = tmr_done ? WR_PRE : WR_DATA;
            WR_PRE:    state_nxt = WR_TRP;
            WR_TRP:    state_nxt = tmr_done ? WR_END : WR_TRP;
            WR_END:    state_nxt = WR_IDLE;
            default:   state_nxt = WR_IDLE;
        endcase
    end

    // timer loads on the cycle before each wait state
    always_comb begin
        tmr_load = 1'b0;
        tmr_val  = '0;
        case (state)
            WR_ACTIVE: begin
                tmr_load = 1'b1;
                tmr_val  = TRCD_CLK;
            end
            WR_WRITE: begin
                tmr_load = 1'b1;
                tmr_val  = wr_burst_len;   // one WR_DATA cycle per beat
            end
            WR_PRE: begin
                tmr_load = 1'b1;
                tmr_val  = TRP_CLK;
            end
            default: ;
        endcase
    end

    // command word that the mux registers one cycle later
    always_comb begin
        wr_cmd = IDLE_CMD;
        case (state)
            WR_ACTIVE: begin
                wr_cmd.cmd      = CMD_ACTIVE;
                wr_cmd.ba       = wr_req.bank;
                wr_cmd.addr.row = wr_req.row;
            end
            WR_WRITE: begin
                wr_cmd.cmd          = CMD_WRITE;
                wr_cmd.ba           = wr_req.bank;
                wr_cmd.addr.col     = '0;       // a10 clear so no auto-precharge
                wr_cmd.addr.col.col = wr_req.col;
            end
            WR_DATA: begin
                if (tmr_done) begin
                    wr_cmd.cmd = CMD_BSTOP;     // lands right after the last beat
                end
            end
            WR_PRE: begin
                wr_cmd.cmd          = CMD_PRECHARGE;
                wr_cmd.ba           = wr_req.bank;
                wr_cmd.addr.col     = '0;
                wr_cmd.addr.col.a10 = 1'b1;
            end
            default: ;
        endcase
    end

    // one cycle late to follow the last tRP NOP on the bus
    always_ff @(posedge sys_clk or negedge sys_rst) begin
        if (!sys_rst) begin
            wr_end <= 1'b0;
        end else begin
            wr_end <= (state == WR_END);
        end
    end

endmodule

// File: verilog/sdram_write_data.sv
/* upstream FIFO read strobes and the registered DQ output with its enable */
`timescale 1ns/1ps

module sdram_write_data import sdram_pkg::*; (
    input  logic        sys_clk,
    input  logic        sys_rst,
    input  wr_phase_e   phase,
    input  logic [9:0]  wr_burst_len,
    input  logic [15:0] wr_data,
    output logic        wr_ack,
    output logic [15:0] dq,
    output logic        dq_oe
);

    logic [10:0] cyc;        // cycles since WR_TRCD was entered
    logic [10:0] beat_idx;   // beat that the current ack asks for
    logic        in_burst;
    logic        beat_en;    // wr_data holds a beat this cycle

    assign in_burst = (phase == WR_TRCD) || (phase == WR_WRITE) || (phase == WR_DATA);
    assign beat_idx = cyc - (11'(TRCD_CLK) - 11'd1);

    always_ff @(posedge sys_clk or negedge sys_rst) begin
        if (!sys_rst) begin
            cyc <= '0;
        end else if (phase == WR_ACTIVE) begin
            cyc <= '0;
        end else if (in_burst) begin
            cyc <= cyc + 11'd1;
        end
    end

    // window opens on the last tRCD cycle two cycles ahead of WRITE on the bus
    assign wr_ack = in_burst && (cyc >= 11'(TRCD_CLK) - 11'd1)
                    && (beat_idx < {1'b0, wr_burst_len});

    always_ff @(posedge sys_clk or negedge sys_rst) begin
        if (!sys_rst) begin
            beat_en <= 1'b0;
            dq_oe   <= 1'b0;
            dq      <= '0;
        end else begin
            beat_en <= wr_ack;                    // data follows the ack by one
            dq_oe   <= beat_en;
            dq      <= beat_en ? wr_data : '0;    // in step with the command register
        end
    end

endmodule

// File: verilog/sdram_cmd_mux.sv
/* SDRAM command pin register, init word before init_end, write word after */
`timescale 1ns/1ps

module sdram_cmd_mux import sdram_pkg::*; (
    input  logic       sys_clk,
    input  logic       sys_rst,
    input  logic       init_end,
    input  sdram_cmd_t init_cmd,
    input  sdram_cmd_t wr_cmd,
    output sdram_cmd_t sdram_bus
);

    sdram_cmd_t cmd_sel;

    // the write FSM only owns the pins once init is finished
    assign cmd_sel = init_end ? wr_cmd : init_cmd;

    // every command reaches the pins one cycle after its state
    always_ff @(posedge sys_clk or negedge sys_rst) begin
        if (!sys_rst) begin
            sdram_bus <= IDLE_CMD;   // NOP, bank and address pins high
        end else begin
            sdram_bus <= cmd_sel;
        end
    end

endmodule

// File: verilog/sdram_write_top.sv
/* SDRAM write controller top: init and write FSMs with their timers,
   write data path and the command pin mux */
`timescale 1ns/1ps

module sdram_write_top import sdram_pkg::*; (
    input  logic        sys_clk,
    input  logic        sys_rst,
    input  logic        wr_en,
    input  wr_addr_t    wr_req,
    input  logic [9:0]  wr_burst_len,
    input  logic [15:0] wr_data,
    output logic        wr_ack,
    output logic        wr_end,
    output logic        init_end,
    output sdram_cmd_t  sdram_bus,
    output logic [15:0] dq,
    output logic        dq_oe
);

    logic       init_tmr_load;
    logic [9:0] init_tmr_val;
    logic       init_tmr_done;
    logic       wr_tmr_load;
    logic [9:0] wr_tmr_val;
    logic       wr_tmr_done;
    sdram_cmd_t init_cmd;
    sdram_cmd_t wr_cmd;
    wr_phase_e  phase;

    sdram_cycle_timer init_timer (
        .sys_clk  (sys_clk),
        .sys_rst  (sys_rst),
        .load     (init_tmr_load),
        .load_val (init_tmr_val),
        .done     (init_tmr_done)
    );

    sdram_cycle_timer write_timer (
        .sys_clk  (sys_clk),
        .sys_rst  (sys_rst),
        .load     (wr_tmr_load),
        .load_val (wr_tmr_val),
        .done     (wr_tmr_done)
    );

    sdram_init u_init (
        .sys_clk  (sys_clk),
        .sys_rst  (sys_rst),
        .tmr_done (init_tmr_done),
        .tmr_load (init_tmr_load),
        .tmr_val  (init_tmr_val),
        .init_cmd (init_cmd),
        .init_end (init_end)
    );

    sdram_write_fsm u_wr_fsm (
        .sys_clk      (sys_clk),
        .sys_rst      (sys_rst),
        .init_end     (init_end),
        .wr_en        (wr_en),
        .wr_req       (wr_req),
        .wr_burst_len (wr_burst_len),
        .tmr_done     (wr_tmr_done),
        .tmr_load     (wr_tmr_load),
        .tmr_val      (wr_tmr_val),
        .phase        (phase),
        .wr_cmd       (wr_cmd),
        .wr_end       (wr_end)
    );

    sdram_write_data u_wr_data (
        .sys_clk      (sys_clk),
        .sys_rst      (sys_rst),
        .phase        (phase),
        .wr_burst_len (wr_burst_len),
        .wr_data      (wr_data),
        .wr_ack       (wr_ack),
        .dq           (dq),
        .dq_oe        (dq_oe)
    );

    sdram_cmd_mux u_cmd_mux (
        .sys_clk   (sys_clk),
        .sys_rst   (sys_rst),
        .init_end  (init_end),
        .init_cmd  (init_cmd),
        .wr_cmd    (wr_cmd),
        .sdram_bus (sdram_bus)
    );

endmodule

// File: sim/sdram_write_tb.sv
/* testbench for the SDRAM write controller: LFSR requests and data words,
   a bus command/data model and immediate-assertion checks */
`timescale 1ns/1ps

module sdram_write_tb import sdram_pkg::*; ();

    localparam int NUM_BURSTS = 12;

    logic        sys_clk;
    logic        sys_rst;
    logic        wr_en;
    wr_addr_t    wr_req;
    logic [9:0]  wr_burst_len;
    logic [15:0] wr_data;
    logic        wr_ack;
    logic        wr_end;
    logic        init_end;
    sdram_cmd_t  sdram_bus;
    logic [15:0] dq;
    logic        dq_oe;

    logic [31:0] lfsr;
    logic [15:0] exp_data[$];   // words handed out but not yet seen on dq
    logic [15:0] data_word;
    int          ack_count;
    int          value_errors;
    int          timeout_errors;
    int          other_errors;
    logic        abort;         // set once a wait times out
    int          burst_no;
    wr_addr_t    next_req;
    logic [9:0]  next_len;

    sdram_write_top UUT (
        .sys_clk      (sys_clk),
        .sys_rst      (sys_rst),
        .wr_en        (wr_en),
        .wr_req       (wr_req),
        .wr_burst_len (wr_burst_len),
        .wr_data      (wr_data),
        .wr_ack       (wr_ack),
        .wr_end       (wr_end),
        .init_end     (init_end),
        .sdram_bus    (sdram_bus),
        .dq           (dq),
        .dq_oe        (dq_oe)
    );

    initial begin
        sys_clk = 1'b0;
        forever #5 sys_clk = ~sys_clk;
    end

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    // one LFSR step per bit taken
    task automatic draw_bits(input int n, output logic [15:0] val);
        int i;
        val = '0;
        for (i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            val  = {val[14:0], lfsr[0]};
        end
    endtask

    task automatic check_val(input string name, input logic [31:0] exp,
                             input logic [31:0] act);
        assert (act === exp) else begin
            value_errors++;
            $display("ERROR %s: expected 0x%0h, actual 0x%0h", name, exp, act);
        end
    endtask

    task automatic step();
        @(negedge sys_clk);
        if (init_end !== 1'b1) begin
            check_val("ACTIVE before init_end", 0, sdram_bus.cmd === CMD_ACTIVE);
        end
    endtask

    // steps until a command other than NOP shows up, counting the NOPs before it
    task automatic wait_cmd(input string what, input int limit,
                            output logic [3:0] cmd, output int nops);
        int i;
        nops = 0;
        cmd  = CMD_NOP;
        for (i = 0; i < limit; i++) begin
            step();
            if (sdram_bus.cmd !== CMD_NOP) begin
                cmd = sdram_bus.cmd;
                return;
            end
            check_val({what, " wait NOP word"}, IDLE_CMD, sdram_bus);
            check_val({what, " wait dq_oe"}, 0, dq_oe);
            check_val({what, " wait wr_end"}, 0, wr_end);
            nops++;
        end
        timeout_errors++;
        abort = 1'b1;
        $display("timeout: %s never appeared on the bus", what);
    endtask

    // NOP cycles until init_end (sel 0) or wr_end (sel 1) goes high
    task automatic wait_flag(input string what, input logic sel, input int limit,
                             output int nops);
        int i;
        nops = 0;
        for (i = 0; i < limit; i++) begin
            step();
            check_val({what, " NOP"}, CMD_NOP, sdram_bus.cmd);
            check_val({what, " dq_oe"}, 0, dq_oe);
            if ((sel ? wr_end : init_end) === 1'b1) begin
                return;
            end
            nops++;
        end
        timeout_errors++;
        abort = 1'b1;
        $display("timeout: %s never went high", what);
    endtask

    task automatic check_beat(input string name);
        check_val({name, " dq_oe"}, 1, dq_oe);
        assert (exp_data.size() > 0) else begin
            other_errors++;
            $display("%s: dq beat came with no supplied word left", name);
        end
        if (exp_data.size() > 0) begin
            check_val({name, " dq"}, exp_data.pop_front(), dq);
        end
    endtask

    task automatic check_init();
        logic [3:0] cmd;
        int         nops;
        wait_cmd("init PRECHARGE", 40 + T_POWERUP, cmd, nops);
        if (abort) return;
        check_val("init power-up NOPs", T_POWERUP, nops);
        check_val("init PRECHARGE cmd", CMD_PRECHARGE, cmd);
        check_val("init PRECHARGE a10", 1, sdram_bus.addr.col.a10);
        wait_cmd("init REFRESH 1", 20, cmd, nops);
        if (abort) return;
        check_val("init tRP NOPs", TRP_CLK, nops);
        check_val("init REFRESH 1 cmd", CMD_REFRESH, cmd);
        wait_cmd("init REFRESH 2", 20, cmd, nops);
        if (abort) return;
        check_val("init tRFC 1 NOPs", TRFC_CLK, nops);
        check_val("init REFRESH 2 cmd", CMD_REFRESH, cmd);
        wait_cmd("init MODE", 20, cmd, nops);
        if (abort) return;
        check_val("init tRFC 2 NOPs", TRFC_CLK, nops);
        check_val("init MODE cmd", CMD_MODE, cmd);
        check_val("init MODE word", MODE_WORD, sdram_bus.addr.row);
        wait_flag("init_end", 1'b0, 20, nops);
        if (abort) return;
        check_val("init tMRD NOPs", TMRD_CLK, nops);
    endtask

    task automatic pick_request(input int idx);
        logic [15:0] r;
        draw_bits(2, r);
        next_req.bank = r[1:0];
        draw_bits(13, r);
        next_req.row = r[12:0];
        draw_bits(9, r);
        next_req.col = r[8:0];
        draw_bits(5, r);
        if (idx < 2) begin
            next_len = 10'(idx + 1);   // shortest bursts first
        end else begin
            next_len = 10'(r[4:0]) + 10'd1;
        end
    endtask

    // one burst from ACTIVE to the wr_end pulse
    task automatic run_burst();
        logic [3:0] cmd;
        int         nops;
        int         beat;
        string      tag;
        tag = $sformatf("burst %0d", burst_no);
        wait_cmd({tag, " ACTIVE"}, 60, cmd, nops);
        if (abort) return;
        ack_count = 0;
        check_val({tag, " ACTIVE cmd"}, CMD_ACTIVE, cmd);
        check_val({tag, " ACTIVE bank"}, wr_req.bank, sdram_bus.ba);
        check_val({tag, " ACTIVE row"}, wr_req.row, sdram_bus.addr.row);
        check_val({tag, " ACTIVE dq_oe"}, 0, dq_oe);
        wait_cmd({tag, " WRITE"}, 20, cmd, nops);
        if (abort) return;
        check_val({tag, " WRITE cmd"}, CMD_WRITE, cmd);
        check_val({tag, " tRCD NOPs"}, TRCD_CLK, nops);
        check_val({tag, " WRITE bank"}, wr_req.bank, sdram_bus.ba);
        check_val({tag, " WRITE col"}, wr_req.col, sdram_bus.addr.col.col);
        check_val({tag, " WRITE a10"}, 0, sdram_bus.addr.col.a10);
        check_beat({tag, " beat 0"});   // first word rides with WRITE
        for (beat = 1; beat < wr_burst_len; beat++) begin
            step();
            check_val({tag, " beat cmd"}, CMD_NOP, sdram_bus.cmd);
            check_beat($sformatf("%s beat %0d", tag, beat));
        end
        step();
        check_val({tag, " BURST STOP"}, CMD_BSTOP, sdram_bus.cmd);
        check_val({tag, " dq_oe after last beat"}, 0, dq_oe);
        check_val({tag, " dq after last beat"}, 0, dq);
        wait_cmd({tag, " PRECHARGE"}, 20, cmd, nops);
        if (abort) return;
        check_val({tag, " PRECHARGE cmd"}, CMD_PRECHARGE, cmd);
        check_val({tag, " PRECHARGE gap"}, 0, nops);
        check_val({tag, " PRECHARGE a10"}, 1, sdram_bus.addr.col.a10);
        check_val({tag, " PRECHARGE bank"}, wr_req.bank, sdram_bus.ba);
        wait_flag({tag, " wr_end"}, 1'b1, 20, nops);
        if (abort) return;
        check_val({tag, " tRP NOPs"}, TRP_CLK, nops);
        check_val({tag, " wr_ack count"}, wr_burst_len, ack_count);
        check_val({tag, " words left over"}, 0, exp_data.size());
    endtask

    // upstream FIFO model with the next word valid the cycle after each ack
    always @(posedge sys_clk) begin
        if (wr_ack === 1'b1) begin
            draw_bits(16, data_word);
            wr_data <= data_word;
            exp_data.push_back(data_word);
            ack_count++;
        end
    end

    initial begin
        int          n;
        logic [15:0] r;
        lfsr           = 32'd32091;
        value_errors   = 0;
        timeout_errors = 0;
        other_errors   = 0;
        abort          = 1'b0;
        ack_count      = 0;
        burst_no       = 0;
        sys_rst        = 1'b0;
        wr_en          = 1'b1;   // high from reset on
        wr_data        = '0;
        pick_request(0);
        wr_req         = next_req;
        wr_burst_len   = next_len;
        repeat (7) @(posedge sys_clk);
        @(negedge sys_clk);
        check_val("reset bus word", IDLE_CMD, sdram_bus);
        check_val("reset ack/end/oe/init", 0, {wr_ack, wr_end, dq_oe, init_end});
        check_val("reset dq", 0, dq);
        @(posedge sys_clk);
        sys_rst <= 1'b1;
        check_init();
        for (n = 0; n < NUM_BURSTS && !abort; n++) begin
            burst_no = n;
            run_burst();
            if (!abort) begin
                pick_request(n + 1);
                draw_bits(2, r);
                @(posedge sys_clk);
                if (n == NUM_BURSTS - 1) begin
                    wr_en <= 1'b0;
                end else if (n == 0 || r[1:0] == 2'd0) begin
                    wr_req       <= next_req;   // back to back
                    wr_burst_len <= next_len;
                end else begin
                    wr_en <= 1'b0;
                    repeat (r[1:0]) @(posedge sys_clk);
                    wr_en        <= 1'b1;
                    wr_req       <= next_req;
                    wr_burst_len <= next_len;
                end
            end
        end
        if (!abort) begin
            for (n = 0; n < 8; n++) begin
                step();
                check_val("idle after last burst", CMD_NOP, sdram_bus.cmd);
                check_val("idle dq_oe", 0, dq_oe);
                check_val("idle wr_end", 0, wr_end);
                check_val("idle wr_ack", 0, wr_ack);
            end
        end
        $display("errors: %0d value, %0d timeout, %0d other",
                 value_errors, timeout_errors, other_errors);
        if (value_errors + timeout_errors + other_errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

// File: sdram_wr.f
verilog/sdram_pkg.sv
verilog/sdram_cycle_timer.sv
verilog/sdram_init.sv
verilog/sdram_write_fsm.sv
verilog/sdram_write_data.sv
verilog/sdram_cmd_mux.sv
verilog/sdram_write_top.sv
sim/sdram_write_tb.sv
